// ==== hw/audPcmPkg.sv ====
// bus and control structs, status codes, address fields, rate divisor table
package audPcmPkg;

	// one bus request as seen on the processor side
	typedef struct packed
	{
		logic [31:0] addr;
		logic [31:0] data;
		logic [4:0]  opm;
	} audBusReq;

	// decoded control register
	typedef struct packed
	{
		logic [3:0] rateSel;
		logic       enable;
		logic       use16;
		logic       compand;
	} audCtrl;

	// status answers
	localparam logic [1:0] busOkReady = 2'd0;
	localparam logic [1:0] busOkOk    = 2'd1;

	// device select in addr[27:16]
	localparam logic [11:0] devSelect = 12'h009;

	// regions inside the device
	localparam logic [1:0] bufRegion     = 2'h0;
	localparam logic [3:0] ctrlRegion    = 4'hF;
	localparam logic [5:0] ctrlRegOffset = 6'h00;

	// control register bit positions, bit 2 reserved
	localparam int ctrlCompandBit = 0;
	localparam int ctrlUse16Bit   = 1;
	localparam int ctrlEnableBit  = 3;
	localparam int ctrlRateLsb    = 4;

	// reload values per rateSel
	localparam logic [13:0] rateDivisorTable [16] = '{
		14'd12500, 14'd9070, 14'd6250, 14'd4535,
		14'd3125,  14'd2268, 14'd1562, 14'd1134,
		14'd781,   14'd2083, 14'd781,  14'd1042,
		14'd781,   14'd781,  14'd781,  14'd781
	};

	// largest entry of the table above
	localparam logic [13:0] rateDivisorMax = 14'd12500;

endpackage

// ==== hw/audBusPort.sv ====
// bus request register, device decode, control register and buffer write strobe
`timescale 1ns/100ps

module audBusPort #(
	parameter int bufferWords = 1024
) (
	input  logic                         clock,
	input  logic                         reset,
	input  audPcmPkg::audBusReq          busReq,
	output logic [1:0]                   busOk,
	output audPcmPkg::audCtrl            ctrl,
	output logic                         bufWrite,
	output logic [$clog2(bufferWords):0] bufAddr,
	output logic [31:0]                  bufData
);

	localparam int idxBits = $clog2(bufferWords);

	audPcmPkg::audBusReq reqQ;
	logic devSel;
	logic isAccess;
	logic isWrite;
	logic ctrlSel;
	logic bufSel;

	// decode works on the registered request
	assign devSel   = (reqQ.addr[27:16] == audPcmPkg::devSelect);
	assign isAccess = |reqQ.opm[4:3];
	assign isWrite  = reqQ.opm[4];
	assign ctrlSel  = (reqQ.addr[15:12] == audPcmPkg::ctrlRegion) &&
		(reqQ.addr[7:2] == audPcmPkg::ctrlRegOffset);
	assign bufSel   = (reqQ.addr[15:14] == audPcmPkg::bufRegion);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqQ     <= '0;
			busOk    <= audPcmPkg::busOkReady;
			ctrl     <= '0;
			bufWrite <= 1'b0;
		end
		else
		begin
			reqQ     <= busReq;
			busOk    <= (devSel && isAccess) ? audPcmPkg::busOkOk : audPcmPkg::busOkReady;
			bufWrite <= devSel && isWrite && bufSel;
			if (devSel && isWrite && ctrlSel)
			begin
				ctrl.compand <= reqQ.data[audPcmPkg::ctrlCompandBit];
				ctrl.use16   <= reqQ.data[audPcmPkg::ctrlUse16Bit];
				ctrl.enable  <= reqQ.data[audPcmPkg::ctrlEnableBit];
				ctrl.rateSel <= reqQ.data[audPcmPkg::ctrlRateLsb +: 4];
			end
		end
	end

	// word address, bit 0 picks the bank
	always_ff @(posedge clock)
	begin
		bufAddr <= reqQ.addr[idxBits + 2:2];
		bufData <= reqQ.data;
	end

	// a buffer strobe must follow a device write that reached the port two cycles earlier
	assert property (@(posedge clock) disable iff (reset)
		bufWrite |-> $past(busReq.opm[4] && busReq.addr[27:16] == audPcmPkg::devSelect, 2));

endmodule

// ==== hw/audSampleBuffer.sv ====
// two-bank sample memory with 32-bit writes and 64-bit block reads
`timescale 1ns/100ps

module audSampleBuffer #(
	parameter int bufferWords = 1024
) (
	input  logic                           clock,
	input  logic                           bufWrite,
	input  logic [$clog2(bufferWords):0]   bufAddr,
	input  logic [31:0]                    bufData,
	input  logic [$clog2(bufferWords)-1:0] readIndex,
	output logic [63:0]                    readBlock
);

	localparam int idxBits = $clog2(bufferWords);

	// bank 0 holds the low word of each block
	logic [31:0] bank [2][bufferWords];

	always_ff @(posedge clock)
	begin
		if (bufWrite)
		begin
			bank[bufAddr[0]][bufAddr[idxBits:1]] <= bufData;
		end
	end

	// one cycle read latency
	always_ff @(posedge clock)
	begin
		readBlock <= {bank[1][readIndex], bank[0][readIndex]};
	end

endmodule

// ==== hw/audRateTimer.sv ====
// sample rate divider stepping the sample position
`timescale 1ns/100ps

module audRateTimer #(
	parameter int bufferWords = 1024
) (
	input  logic                             clock,
	input  logic                             reset,
	input  audPcmPkg::audCtrl                ctrl,
	output logic [$clog2(bufferWords)+2:0]   samplePos
);

	logic [13:0] reload;
	logic [13:0] count;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reload    <= '0;
			count     <= '0;
			samplePos <= '0;
		end
		else
		begin
			// table lookup one cycle ahead of use
			reload <= audPcmPkg::rateDivisorTable[ctrl.rateSel];
			if (count == '0)
			begin
				count     <= reload;
				samplePos <= samplePos + 1'b1;
			end
			else
			begin
				count <= count - 1'b1;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		count <= audPcmPkg::rateDivisorMax);

endmodule

// ==== hw/audSampleDecode.sv ====
// sample select and expansion of 8-bit, companded and 16-bit formats
`timescale 1ns/100ps

module audSampleDecode #(
	parameter int bufferWords = 1024
) (
	input  logic                             clock,
	input  logic                             reset,
	input  audPcmPkg::audCtrl                ctrl,
	input  logic [$clog2(bufferWords)+2:0]   samplePos,
	input  logic [63:0]                      readBlock,
	output logic [$clog2(bufferWords)-1:0]   readIndex,
	output logic [15:0]                      pcmSample
);

	localparam int idxBits = $clog2(bufferWords);

	logic [2:0]  selQ;
	logic [7:0]  raw8;
	logic [15:0] raw16;
	logic [2:0]  expo;
	logic [3:0]  mant;
	logic [10:0] mag;
	logic [11:0] companded;
	logic [11:0] next12;
	logic [11:0] sample12;

	// four samples per block in 16-bit mode, eight otherwise
	assign readIndex = ctrl.use16 ? samplePos[idxBits + 1:2] : samplePos[idxBits + 2:3];

	// low position bits travel alongside the block read
	always_ff @(posedge clock)
	begin
		selQ  <= samplePos[2:0];
		raw8  <= readBlock[selQ * 8 +: 8];
		raw16 <= readBlock[selQ[1:0] * 16 +: 16];
	end

	assign expo = raw8[6:4];
	assign mant = raw8[3:0];

	// exponent 0 is denormal, each step up doubles the spacing
	always_comb
	begin
		if (expo == 3'd0)
		begin
			mag = {7'h00, mant};
		end
		else
		begin
			mag = {1'b1, mant, mant, 2'b00} >> (3'd7 - expo);
		end
	end

	assign companded = raw8[7] ? {~mag, ~mag[10]} : {mag, mag[10]};

	always_comb
	begin
		if (ctrl.use16)
		begin
			// linear 16-bit is offset binary unless companded
			next12 = {raw16[15] ^ ~ctrl.compand, raw16[14:4]};
		end
		else if (ctrl.compand)
		begin
			next12 = companded;
		end
		else
		begin
			next12 = {~raw8[7], raw8[6:0], 4'h0};
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sample12  <= '0;
			pcmSample <= '0;
		end
		else
		begin
			sample12  <= next12;
			// top nibble repeated into the low bits
			pcmSample <= {sample12, sample12[11:8]};
		end
	end

endmodule

// ==== hw/audMixPwm.sv ====
// aux and noise mixer with two first-order delta-sigma modulators
`timescale 1ns/100ps

module audMixPwm (
	input  logic              clock,
	input  logic              reset,
	input  audPcmPkg::audCtrl ctrl,
	input  logic [15:0]       pcmSample,
	input  logic [7:0]        auxLeft,
	input  logic [7:0]        auxRight,
	input  logic              noise,
	output logic [1:0]        pwmBits
);

	logic [7:0] auxQ [2];
	logic       noiseQ;

	always_ff @(posedge clock)
	begin
		auxQ[0] <= auxLeft;
		auxQ[1] <= auxRight;
		noiseQ  <= noise;
	end

	// channel 0 is left, channel 1 is right
	for (genvar ch = 0; ch < 2; ch++)
	begin : gChannel
		logic [15:0] mixed;
		logic [15:0] mixQ;
		logic [15:0] valQ;
		logic [15:0] acc;
		logic [16:0] sum;

		// sample scaled down by 16, aux sits at bits 11:4
		assign mixed = {{4{pcmSample[15]}}, pcmSample[15:4]} +
			{{4{auxQ[ch][7]}}, auxQ[ch], 3'b000, noiseQ};

		always_ff @(posedge clock)
		begin
			mixQ <= mixed;
			// signed to offset binary
			valQ <= {~mixQ[15], mixQ[14:0]};
		end

		assign sum = {1'b0, acc} + {1'b0, valQ};

		// accumulator restarts from zero while output is off
		always_ff @(posedge clock)
		begin
			if (reset || !ctrl.enable)
			begin
				acc <= '0;
			end
			else
			begin
				acc <= sum[15:0];
			end
		end

		assign pwmBits[ch] = ctrl.enable ? sum[16] : 1'b1;
	end

endmodule

// ==== hw/audPcm.sv ====
// PCM sound device top level with registered PWM outputs
`timescale 1ns/100ps

module audPcm #(
	parameter int bufferWords = 1024
) (
	input  logic                clock,
	input  logic                reset,
	input  audPcmPkg::audBusReq busReq,
	output logic [1:0]          busOk,
	input  logic [7:0]          auxLeft,
	input  logic [7:0]          auxRight,
	input  logic                noise,
	output logic [1:0]          pwmOut,
	output logic                pwmEna
);

	localparam int idxBits = $clog2(bufferWords);

	audPcmPkg::audCtrl  ctrl;
	logic               bufWrite;
	logic [idxBits:0]   bufAddr;
	logic [31:0]        bufData;
	logic [idxBits+2:0] samplePos;
	logic [idxBits-1:0] readIndex;
	logic [63:0]        readBlock;
	logic [15:0]        pcmSample;
	logic [1:0]         pwmBits;

	audBusPort #(.bufferWords(bufferWords)) busPort (
		.clock(clock),
		.reset(reset),
		.busReq(busReq),
		.busOk(busOk),
		.ctrl(ctrl),
		.bufWrite(bufWrite),
		.bufAddr(bufAddr),
		.bufData(bufData)
	);

	audSampleBuffer #(.bufferWords(bufferWords)) sampleBuffer (
		.clock(clock),
		.bufWrite(bufWrite),
		.bufAddr(bufAddr),
		.bufData(bufData),
		.readIndex(readIndex),
		.readBlock(readBlock)
	);

	audRateTimer #(.bufferWords(bufferWords)) rateTimer (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl),
		.samplePos(samplePos)
	);

	audSampleDecode #(.bufferWords(bufferWords)) sampleDecode (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl),
		.samplePos(samplePos),
		.readBlock(readBlock),
		.readIndex(readIndex),
		.pcmSample(pcmSample)
	);

	audMixPwm mixPwm (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl),
		.pcmSample(pcmSample),
		.auxLeft(auxLeft),
		.auxRight(auxRight),
		.noise(noise),
		.pwmBits(pwmBits)
	);

	// output stage, idle level is both ones
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pwmOut <= 2'b11;
			pwmEna <= 1'b0;
		end
		else
		begin
			pwmOut <= pwmBits;
			pwmEna <= ctrl.enable;
		end
	end

endmodule

// ==== verif/audPcmClock.sv ====
// testbench clock and reset generator
`timescale 1ns/100ps

module audPcmClock #(
	parameter int periodNs    = 10,
	parameter int resetCycles = 5
) (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(periodNs / 2) clock = ~clock;
		end
	end

	// released just after a rising edge
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

// ==== verif/audPcmTb.sv ====
// testbench with bus stimulus, reference level model, PWM ones counter and watchdog
`timescale 1ns/100ps

module audPcmTb;

	localparam int bufferWords  = 1024;
	localparam int windowCycles = 65536;
	localparam int windowCount  = 43;
	localparam int fillCount    = 26;
	localparam int clockPeriod  = 10;
	localparam int settleCycles = 16;
	localparam longint watchdogNs = longint'(windowCount * (windowCycles + 40) +
		fillCount * (2 * bufferWords + 8) + 2000) * clockPeriod;
	localparam logic [31:0] ctrlAddr = {4'h0, audPcmPkg::devSelect, 16'hF000};
	localparam logic [31:0] bufBase  = {4'h0, audPcmPkg::devSelect, 16'h0000};

	logic                clock;
	logic                reset;
	audPcmPkg::audBusReq busReq;
	logic [1:0]          busOk;
	logic [7:0]          auxLeft;
	logic [7:0]          auxRight;
	logic                noise;
	logic [1:0]          pwmOut;
	logic                pwmEna;

	integer      seed = 32'hda6c;
	int          errorCount = 0;
	int          checkCount = 0;
	int          expLeft;
	int          expRight;
	logic [15:0] sample;
	event        startWindow;
	event        windowDone;

	audPcmClock #(.periodNs(clockPeriod), .resetCycles(5)) clockGen (
		.clock(clock),
		.reset(reset)
	);

	audPcm #(.bufferWords(bufferWords)) UUT (
		.clock(clock),
		.reset(reset),
		.busReq(busReq),
		.busOk(busOk),
		.auxLeft(auxLeft),
		.auxRight(auxRight),
		.noise(noise),
		.pwmOut(pwmOut),
		.pwmEna(pwmEna)
	);

	task automatic checkValue(input string name, input longint expected, input longint actual,
		input int tolerance);
		checkCount++;
		if (actual > expected + tolerance || actual < expected - tolerance)
		begin
			errorCount++;
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	// expected offset-binary level of one channel
	function automatic int expectedLevel(input logic compand, input logic use16,
		input logic [15:0] raw, input logic [7:0] aux, input logic noiseBit);
		int level;
		int mag;
		int expo;
		int mant;
		int auxValue;
		expo = raw[6:4];
		mant = raw[3:0];
		if (use16)
		begin
			// top 12 bits, two's complement only when companded
			level = raw[15:4];
			if (!compand)
				level = level - 2048;
			else if (level >= 2048)
				level = level - 4096;
		end
		else if (!compand)
		begin
			level = raw[7:0];
			level = (level - 128) * 16;
		end
		else
		begin
			// denormal at exponent 0, else leading one and mantissa repeated below
			mag = (expo == 0) ? mant : (1024 + 68 * mant) >> (7 - expo);
			level = 2 * mag + mag / 1024;
			if (raw[7])
				level = 4095 - level;
			if (level >= 2048)
				level = level - 4096;
		end
		auxValue = aux;
		if (auxValue >= 128)
			auxValue = auxValue - 256;
		return level + 16 * auxValue + noiseBit + 32768;
	endfunction

	task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
		busReq.addr = addr;
		busReq.data = data;
		busReq.opm  = 5'b10000;
		@(posedge clock);
		#1;
		busReq.opm = 5'b00000;
	endtask

	task automatic writeControl(input logic compand, input logic use16, input logic enable,
		input logic [3:0] rateSel);
		busWrite(ctrlAddr, {24'h0, rateSel, enable, 1'b0, use16, compand});
	endtask

	task automatic fillBuffer(input logic [31:0] word);
		for (int i = 0; i < 2 * bufferWords; i++)
		begin
			busWrite(bufBase + (i << 2), word);
		end
	endtask

	// answer must be ready one cycle on and only then ok
	task automatic busProbe(input logic [31:0] addr, input logic [4:0] opm, input logic hit);
		busReq.addr = addr;
		busReq.opm  = opm;
		@(posedge clock);
		#1;
		busReq.opm = 5'b00000;
		checkValue("busOk", audPcmPkg::busOkReady, busOk, 0);
		@(posedge clock);
		#1;
		checkValue("busOk", hit ? audPcmPkg::busOkOk : audPcmPkg::busOkReady, busOk, 0);
	endtask

	task automatic enableStep(input logic enable);
		writeControl(1'b0, 1'b0, enable, 4'd0);
		@(posedge clock);
		#1;
		checkValue("pwmEna", !enable, pwmEna, 0);
		@(posedge clock);
		#1;
		checkValue("pwmEna", enable, pwmEna, 0);
		if (!enable)
			checkValue("pwmOut", 3, pwmOut, 0);
	endtask

	task automatic measureSample(input logic compand, input logic use16,
		input logic [15:0] raw, input logic [7:0] auxL, input logic [7:0] auxR,
		input logic noiseBit, input logic [3:0] rateSel, input logic refill);
		if (refill)
			fillBuffer(use16 ? {2{raw}} : {4{raw[7:0]}});
		auxLeft  = auxL;
		auxRight = auxR;
		noise    = noiseBit;
		writeControl(compand, use16, 1'b1, rateSel);
		expLeft  = expectedLevel(compand, use16, raw, auxL, noiseBit);
		expRight = expectedLevel(compand, use16, raw, auxR, noiseBit);
		repeat (settleCycles) @(posedge clock);
		#1;
		-> startWindow;
		@(windowDone);
		@(posedge clock);
		#1;
	endtask

	// ones per window, sampled away from the output edge
	always
	begin : onesCounter
		int onesLeft;
		int onesRight;
		@(startWindow);
		onesLeft  = 0;
		onesRight = 0;
		repeat (windowCycles)
		begin
			@(negedge clock);
			onesLeft  += pwmOut[0];
			onesRight += pwmOut[1];
		end
		checkValue("pwmOut[0] ones", (longint'(expLeft) * windowCycles) / 65536, onesLeft, 1);
		checkValue("pwmOut[1] ones", (longint'(expRight) * windowCycles) / 65536, onesRight, 1);
		-> windowDone;
	end

	initial
	begin
		busReq   = '0;
		auxLeft  = '0;
		auxRight = '0;
		noise    = 1'b0;
		@(negedge reset);
		@(posedge clock);
		#1;
		checkValue("pwmOut", 3, pwmOut, 0);
		checkValue("pwmEna", 0, pwmEna, 0);
		// device hits, then foreign addresses and idle opm codes
		busProbe(32'h0009_0010, 5'b01000, 1'b1);
		busProbe(32'h0009_F000, 5'b01000, 1'b1);
		busProbe(32'h0009_8004, 5'b01000, 1'b1);
		busProbe(32'h0009_0020, 5'b10000, 1'b1);
		busProbe(32'h0008_0010, 5'b01000, 1'b0);
		busProbe(32'h000A_0020, 5'b10000, 1'b0);
		busProbe(32'h0009_0010, 5'b00111, 1'b0);
		busProbe(32'h0009_F000, 5'b00000, 1'b0);
		enableStep(1'b1);
		enableStep(1'b0);
		repeat (4)
		begin
			sample = $random(seed);
			measureSample(1'b0, 1'b0, sample, 8'h00, 8'h00, 1'b0, 4'd8, 1'b1);
		end
		// sign in bit 0 of e, exponent above it
		for (int e = 0; e < 16; e++)
		begin
			sample = $random(seed);
			sample[7:4] = {e[0], e[3:1]};
			measureSample(1'b1, 1'b0, sample, 8'h00, 8'h00, 1'b0, 4'd8, 1'b1);
		end
		for (int i = 0; i < 4; i++)
		begin
			sample = $random(seed);
			measureSample(i[0], 1'b1, sample, 8'h00, 8'h00, 1'b0, 4'd12, 1'b1);
		end
		sample = $random(seed);
		measureSample(1'b0, 1'b0, sample, 8'h10, 8'hF0, 1'b0, 4'd8, 1'b1);
		measureSample(1'b0, 1'b0, sample, 8'h7F, 8'h80, 1'b1, 4'd8, 1'b0);
		measureSample(1'b0, 1'b0, sample, 8'hC3, 8'h25, 1'b0, 4'd8, 1'b0);
		sample = $random(seed);
		for (int r = 0; r < 16; r++)
		begin
			measureSample(1'b0, 1'b0, sample, 8'h00, 8'h00, 1'b0, r[3:0], r == 0);
		end
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial
	begin
		#(watchdogNs);
		$display("watchdog expired before the test sequence finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== audPcm.f ====
hw/audPcmPkg.sv
hw/audBusPort.sv
hw/audSampleBuffer.sv
hw/audRateTimer.sv
hw/audSampleDecode.sv
hw/audMixPwm.sv
hw/audPcm.sv
verif/audPcmClock.sv
verif/audPcmTb.sv

// ==== Bender.yml ====
package:
  name: audPcm

sources:
  - hw/audPcmPkg.sv
  - hw/audBusPort.sv
  - hw/audSampleBuffer.sv
  - hw/audRateTimer.sv
  - hw/audSampleDecode.sv
  - hw/audMixPwm.sv
  - hw/audPcm.sv
  - target: simulation
    files:
      - verif/audPcmClock.sv
      - verif/audPcmTb.sv
